//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // instruction format widths
    localparam int opCodeW = 4;
    localparam int regIdxW = 3;

    typedef logic [regIdxW-1:0] regIdxT;
    typedef logic [1:0] aluOpT;
    typedef logic [1:0] numBytesT;
    typedef logic [1:0] wbDataT;

    typedef enum logic [opCodeW-1:0] {
        opAnd  = 4'd0,
        opAdd  = 4'd1,
        opSub  = 4'd2,
        opAddi = 4'd3,
        opAndi = 4'd4,
        opLw   = 4'd5,
        opLb   = 4'd6,
        opSw   = 4'd7,
        opBgt  = 4'd8,
        opBlt  = 4'd9,
        opBeq  = 4'd10,
        opBne  = 4'd11,
        opJmp  = 4'd12,
        opCall = 4'd13,
        opRet  = 4'd14,
        opSv   = 4'd15
    } opCodeT;

    // msb first, 16 bits in total
    typedef struct packed {
        logic     src1;
        logic     src2;
        logic     regDst;
        logic     extOp;
        logic     extPlace;
        logic     aluSrc;
        aluOpT    aluOp;
        logic     dataInSrc;
        logic     memRd;
        logic     memWr;
        numBytesT numBytes;
        wbDataT   wbData;
        logic     regWr;
    } ctrlWordT;

    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdEx   = 2'd1,
        fwdMem  = 2'd2,
        fwdWb   = 2'd3
    } fwdSelT;

    typedef enum logic [1:0] {
        pcNext   = 2'd0,
        pcJump   = 2'd1,
        pcBranch = 2'd2,
        pcReturn = 2'd3
    } pcSrcT;

    // what the hazard logic needs from an instruction in flight
    typedef struct packed {
        regIdxT rd;
        logic   regWr;
        logic   memRd;
    } stageEntryT;

    typedef struct packed {
        opCodeT opCode;
        logic   mode;
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
    } instFieldsT;

    localparam regIdxT regZero = '0;

    localparam aluOpT aluAnd = 2'd0;
    localparam aluOpT aluAdd = 2'd1;
    localparam aluOpT aluSub = 2'd2;

    // write-back source select
    localparam wbDataT wbPc  = 2'd0;
    localparam wbDataT wbAlu = 2'd1;
    localparam wbDataT wbMem = 2'd2;

    localparam ctrlWordT ctrlNop = '0;
    localparam stageEntryT bubbleEntry = '0;

endpackage

`default_nettype wire

//--- logic/mainDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
    input  cpuPkg::opCodeT   opCode,
    input  logic             mode,
    input  logic             stall,
    output cpuPkg::ctrlWordT ctrl
);
    import cpuPkg::*;

    always_comb begin
        ctrl = ctrlNop;
        if (!stall) begin
            case (opCode)
                opAnd, opAdd, opSub: begin
                    ctrl.src2   = 1'b1;
                    ctrl.wbData = wbAlu;
                    ctrl.regWr  = 1'b1;
                    if (opCode == opAnd) begin
                        ctrl.aluOp = aluAnd;
                    end else if (opCode == opAdd) begin
                        ctrl.aluOp = aluAdd;
                    end else begin
                        ctrl.aluOp = aluSub;
                    end
                end
                opAddi, opAndi: begin
                    ctrl.extOp  = 1'b1;
                    ctrl.aluSrc = 1'b1;
                    ctrl.aluOp  = (opCode == opAddi) ? aluAdd : aluAnd;
                    ctrl.wbData = wbAlu;
                    ctrl.regWr  = 1'b1;
                end
                opLw, opLb: begin
                    ctrl.extOp  = 1'b1;
                    ctrl.aluSrc = 1'b1;
                    ctrl.aluOp  = aluAdd;
                    ctrl.memRd  = 1'b1;
                    ctrl.wbData = wbMem;
                    ctrl.regWr  = 1'b1;
                    // byte load width picked by mode
                    if (opCode == opLb) begin
                        ctrl.numBytes = mode ? 2'd2 : 2'd1;
                    end
                end
                opSw: begin
                    ctrl.extOp     = 1'b1;
                    ctrl.aluSrc    = 1'b1;
                    ctrl.aluOp     = aluAdd;
                    ctrl.dataInSrc = 1'b1;
                    ctrl.memWr     = 1'b1;
                    ctrl.numBytes  = 2'd2;
                end
                opBgt, opBlt, opBeq, opBne: begin
                    // mode picks which operand the compare reads
                    ctrl.src1  = mode;
                    ctrl.extOp = 1'b1;
                end
                opCall: begin
                    ctrl.regDst = 1'b1;
                    ctrl.wbData = wbPc;
                    ctrl.regWr  = 1'b1;
                end
                opSv: begin
                    ctrl.src1     = 1'b1;
                    ctrl.extPlace = 1'b1;
                    ctrl.aluOp    = aluAdd;
                    ctrl.memWr    = 1'b1;
                end
                // jmp and ret drive nothing beyond the pc path
                default: begin
                    ctrl = ctrlNop;
                end
            endcase
        end
    end

    // a single memory access per instruction
    always_comb begin
        assert (!(ctrl.memRd && ctrl.memWr))
            else $error("mainDecoder: memRd and memWr both set");
    end

endmodule

`default_nettype wire

//--- logic/pcSelect.sv
`timescale 1ns/1ps
`default_nettype none

module pcSelect (
    input  cpuPkg::opCodeT opCode,
    input  logic           gt,
    input  logic           lt,
    input  logic           eq,
    input  logic           stall,
    output cpuPkg::pcSrcT  pcSrc,
    output logic           kill
);
    import cpuPkg::*;

    logic taken;

    // branch resolution on the compare levels
    always_comb begin
        case (opCode)
            opBgt:   taken = gt;
            opBlt:   taken = lt;
            opBeq:   taken = eq;
            opBne:   taken = !eq;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        pcSrc = pcNext;
        kill  = 1'b0;
        if (!stall) begin
            if (taken) begin
                pcSrc = pcBranch;
                kill  = 1'b1;
            end else if (opCode == opJmp || opCode == opCall) begin
                pcSrc = pcJump;
                kill  = 1'b1;
            end else if (opCode == opRet) begin
                pcSrc = pcReturn;
                kill  = 1'b1;
            end
        end
    end

    // fetch is flushed on every redirect and only then
    always_comb begin
        assert (kill == (pcSrc != pcNext))
            else $error("pcSelect: kill does not match pcSrc");
    end

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  cpuPkg::regIdxT     rs1,
    input  cpuPkg::regIdxT     rs2,
    input  cpuPkg::stageEntryT exEntry,
    input  cpuPkg::stageEntryT memEntry,
    input  cpuPkg::stageEntryT wbEntry,
    output logic               stall,
    output cpuPkg::fwdSelT     fwdA,
    output cpuPkg::fwdSelT     fwdB
);
    import cpuPkg::*;

    // nearest writer wins, r0 is hardwired and never forwarded
    function automatic fwdSelT pickFwd(
        input regIdxT     rs,
        input stageEntryT ex,
        input stageEntryT mem,
        input stageEntryT wb
    );
        fwdSelT sel;
        sel = fwdNone;
        if (rs != regZero) begin
            if (ex.regWr && ex.rd == rs) begin
                sel = fwdEx;
            end else if (mem.regWr && mem.rd == rs) begin
                sel = fwdMem;
            end else if (wb.regWr && wb.rd == rs) begin
                sel = fwdWb;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwdA = pickFwd(rs1, exEntry, memEntry, wbEntry);
        fwdB = pickFwd(rs2, exEntry, memEntry, wbEntry);
    end

    // load data is not ready in EX, hold decode for a cycle
    always_comb begin
        stall = exEntry.memRd && (fwdA == fwdEx || fwdB == fwdEx);
    end

endmodule

`default_nettype wire

//--- logic/stageTracker.sv
`timescale 1ns/1ps
`default_nettype none

module stageTracker (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::stageEntryT decodeEntry,
    input  logic               stall,
    input  logic               kill,
    output cpuPkg::stageEntryT exEntry,
    output cpuPkg::stageEntryT memEntry,
    output cpuPkg::stageEntryT wbEntry
);
    import cpuPkg::*;

    stageEntryT exNext;

    // bubble into EX on a held or flushed decode
    always_comb begin
        if (stall || kill) begin
            exNext = bubbleEntry;
        end else begin
            exNext = decodeEntry;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exEntry  <= bubbleEntry;
            memEntry <= bubbleEntry;
            wbEntry  <= bubbleEntry;
        end else begin
            exEntry  <= exNext;
            memEntry <= exEntry;
            wbEntry  <= memEntry;
        end
    end

    // a held decode leaves a bubble in EX
    stallBubble: assert property (
        @(posedge clk) disable iff (!rstN)
        stall |=> (exEntry == bubbleEntry)
    ) else $error("stageTracker: no bubble after stall");

endmodule

`default_nettype wire

//--- logic/controlTop.sv
`timescale 1ns/1ps
`default_nettype none

module controlTop (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::instFieldsT inst,
    input  logic               gt,
    input  logic               lt,
    input  logic               eq,
    output cpuPkg::ctrlWordT   ctrl,
    output cpuPkg::pcSrcT      pcSrc,
    output logic               kill,
    output logic               stall,
    output cpuPkg::fwdSelT     fwdA,
    output cpuPkg::fwdSelT     fwdB
);
    import cpuPkg::*;

    stageEntryT decodeEntry;
    stageEntryT exEntry;
    stageEntryT memEntry;
    stageEntryT wbEntry;

    // decode slot as seen by the tracker
    assign decodeEntry = '{rd: inst.rd, regWr: ctrl.regWr, memRd: ctrl.memRd};

    hazardUnit hazardUnit_inst (
        .rs1      (inst.rs1),
        .rs2      (inst.rs2),
        .exEntry  (exEntry),
        .memEntry (memEntry),
        .wbEntry  (wbEntry),
        .stall    (stall),
        .fwdA     (fwdA),
        .fwdB     (fwdB)
    );

    mainDecoder mainDecoder_inst (
        .opCode (inst.opCode),
        .mode   (inst.mode),
        .stall  (stall),
        .ctrl   (ctrl)
    );

    pcSelect pcSelect_inst (
        .opCode (inst.opCode),
        .gt     (gt),
        .lt     (lt),
        .eq     (eq),
        .stall  (stall),
        .pcSrc  (pcSrc),
        .kill   (kill)
    );

    stageTracker stageTracker_inst (
        .clk         (clk),
        .rstN        (rstN),
        .decodeEntry (decodeEntry),
        .stall       (stall),
        .kill        (kill),
        .exEntry     (exEntry),
        .memEntry    (memEntry),
        .wbEntry     (wbEntry)
    );

endmodule

`default_nettype wire

//--- testbench/controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// control word fields msb first
// src1 src2 regDst extOp extPlace aluSrc | aluOp | dataInSrc memRd memWr
// | numBytes | wbData | regWr
function automatic ctrlWordT controlWord(input opCodeT op, input logic mode, input logic held);
    logic [15:0] w;
    w = 16'b0;
    case (op)
        opAnd:  w = 16'b010000_00_000_00_01_1;
        opAdd:  w = 16'b010000_01_000_00_01_1;
        opSub:  w = 16'b010000_10_000_00_01_1;
        opAddi: w = 16'b000101_01_000_00_01_1;
        opAndi: w = 16'b000101_00_000_00_01_1;
        opLw:   w = 16'b000101_01_010_00_10_1;
        opLb:   w = mode ? 16'b000101_01_010_10_10_1 : 16'b000101_01_010_01_10_1;
        opSw:   w = 16'b000101_01_101_10_00_0;
        opBgt, opBlt, opBeq, opBne: begin
            w = mode ? 16'b100100_00_000_00_00_0 : 16'b000100_00_000_00_00_0;
        end
        opCall: w = 16'b001000_00_000_00_00_1;
        opSv:   w = 16'b100010_01_001_00_00_0;
        default: w = 16'b0;
    endcase
    // held decode slot issues nothing
    if (held) begin
        w = 16'b0;
    end
    return ctrlWordT'(w);
endfunction

function automatic pcSrcT pcRedirect(input opCodeT op, input logic g, input logic l,
                                     input logic e, input logic held);
    pcSrcT s;
    s = pcNext;
    case (op)
        opBgt:         s = g ? pcBranch : pcNext;
        opBlt:         s = l ? pcBranch : pcNext;
        opBeq:         s = e ? pcBranch : pcNext;
        opBne:         s = e ? pcNext : pcBranch;
        opJmp, opCall: s = pcJump;
        opRet:         s = pcReturn;
        default:       s = pcNext;
    endcase
    if (held) begin
        s = pcNext;
    end
    return s;
endfunction

// farthest stage first so a nearer writer overrides it
function automatic fwdSelT forwardSource(input regIdxT rs, input stageEntryT ex,
                                         input stageEntryT mem, input stageEntryT wb);
    fwdSelT s;
    s = fwdNone;
    if (wb.regWr && wb.rd == rs) begin
        s = fwdWb;
    end
    if (mem.regWr && mem.rd == rs) begin
        s = fwdMem;
    end
    if (ex.regWr && ex.rd == rs) begin
        s = fwdEx;
    end
    if (rs == 3'd0) begin
        s = fwdNone;
    end
    return s;
endfunction

function automatic logic loadUseStall(input regIdxT rs1, input regIdxT rs2,
                                      input stageEntryT ex, input stageEntryT mem,
                                      input stageEntryT wb);
    logic useEx;
    useEx = (forwardSource(rs1, ex, mem, wb) == fwdEx)
        || (forwardSource(rs2, ex, mem, wb) == fwdEx);
    return ex.memRd && useEx;
endfunction

`endif

//--- testbench/controlTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlTb;
    import cpuPkg::*;

    `include "controlModel.svh"

    localparam int clkHalf = 2;
    localparam int resetCycles = 8;
    localparam int randomCount = 500;
    localparam int stallLimit = 8;
    localparam int timeLimitNs = 20000;

    logic       clk;
    logic       rstN;
    instFieldsT inst;
    logic       gt;
    logic       lt;
    logic       eq;
    ctrlWordT   ctrl;
    pcSrcT      pcSrc;
    logic       kill;
    logic       stall;
    fwdSelT     fwdA;
    fwdSelT     fwdB;

    // shadow of the EX, MEM and WB entries
    stageEntryT exS;
    stageEntryT memS;
    stageEntryT wbS;

    int errCount;
    int checkCount;
    int testErrStart;

    controlTop controlTop_inst (
        .clk   (clk),
        .rstN  (rstN),
        .inst  (inst),
        .gt    (gt),
        .lt    (lt),
        .eq    (eq),
        .ctrl  (ctrl),
        .pcSrc (pcSrc),
        .kill  (kill),
        .stall (stall),
        .fwdA  (fwdA),
        .fwdB  (fwdB)
    );

    initial begin
        clk = 1'b0;
        forever #clkHalf clk = ~clk;
    end

    always @(posedge clk or negedge rstN) begin
        ctrlWordT c;
        logic held;
        if (!rstN) begin
            exS  <= '0;
            memS <= '0;
            wbS  <= '0;
        end else begin
            held = loadUseStall(inst.rs1, inst.rs2, exS, memS, wbS);
            c = controlWord(inst.opCode, inst.mode, held);
            if (held || pcRedirect(inst.opCode, gt, lt, eq, held) != pcNext) begin
                exS <= '0;
            end else begin
                exS <= '{rd: inst.rd, regWr: c.regWr, memRd: c.memRd};
            end
            memS <= exS;
            wbS  <= memS;
        end
    end

    task automatic reportMismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
        $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
        errCount++;
    endtask

    // outputs settle well before the next rising edge
    always @(negedge clk) begin
        logic     held;
        ctrlWordT expCtrl;
        pcSrcT    expPc;
        fwdSelT   expA;
        fwdSelT   expB;
        #1;
        held = loadUseStall(inst.rs1, inst.rs2, exS, memS, wbS);
        expCtrl = controlWord(inst.opCode, inst.mode, held);
        expPc = pcRedirect(inst.opCode, gt, lt, eq, held);
        expA = forwardSource(inst.rs1, exS, memS, wbS);
        expB = forwardSource(inst.rs2, exS, memS, wbS);
        checkCount++;
        assert (stall === held) else reportMismatch("stall", 16'(stall), 16'(held));
        assert (ctrl === expCtrl) else reportMismatch("ctrl", ctrl, expCtrl);
        assert (pcSrc === expPc) else reportMismatch("pcSrc", 16'(pcSrc), 16'(expPc));
        assert (kill === (expPc != pcNext))
            else reportMismatch("kill", 16'(kill), 16'(expPc != pcNext));
        assert (fwdA === expA) else reportMismatch("fwdA", 16'(fwdA), 16'(expA));
        assert (fwdB === expB) else reportMismatch("fwdB", 16'(fwdB), 16'(expB));
    end

    task automatic driveInst(input opCodeT op, input logic mode, input regIdxT rs1,
                             input regIdxT rs2, input regIdxT rd, input logic [2:0] flags);
        @(negedge clk);
        inst = '{opCode: op, mode: mode, rs1: rs1, rs2: rs2, rd: rd};
        {gt, lt, eq} = flags;
    endtask

    task automatic applyReset();
        int i;
        @(negedge clk);
        rstN = 1'b0;
        inst = '0;
        for (i = 0; i < resetCycles; i++) begin
            @(negedge clk);
        end
        rstN = 1'b1;
    endtask

    task automatic finishTest(input string name);
        @(posedge clk);
        $display("%s: %0d errors", name, errCount - testErrStart);
        testErrStart = errCount;
    endtask

    task automatic waitStallClear();
        int  n;
        logic clear;
        clear = 1'b0;
        for (n = 0; n < stallLimit && !clear; n++) begin
            @(negedge clk);
            #1;
            clear = !stall;
        end
        if (!clear) begin
            $display("stall stayed high for %0d cycles after a load-use hazard", stallLimit);
            errCount++;
        end
    endtask

    initial begin
        #(timeLimitNs);
        $display("simulation ran past its time limit of %0d ns", timeLimitNs);
        $display("Test failed");
        $finish;
    end

    initial begin
        int o;
        int m;
        int f;
        int i;
        logic [31:0] r;
        logic hold;
        void'($urandom(63));
        rstN = 1'b0;
        inst = '0;
        {gt, lt, eq} = 3'b000;
        errCount = 0;
        checkCount = 0;
        testErrStart = 0;
        applyReset();

        for (o = 0; o < 16; o++) begin
            for (m = 0; m < 2; m++) begin
                driveInst(opCodeT'(o[3:0]), m[0], 3'd0, 3'd0, 3'd0, 3'b000);
            end
        end
        finishTest("control table");

        for (o = 8; o < 12; o++) begin
            for (f = 0; f < 8; f++) begin
                driveInst(opCodeT'(o[3:0]), 1'b0, 3'd0, 3'd0, 3'd0, f[2:0]);
            end
        end
        driveInst(opJmp, 1'b0, 3'd0, 3'd0, 3'd0, 3'b111);
        driveInst(opCall, 1'b0, 3'd0, 3'd0, 3'd7, 3'b000);
        driveInst(opRet, 1'b0, 3'd0, 3'd0, 3'd0, 3'b010);
        finishTest("branch and jump redirect");

        driveInst(opAddi, 1'b0, 3'd0, 3'd0, 3'd0, 3'b000);
        driveInst(opAddi, 1'b0, 3'd0, 3'd0, 3'd2, 3'b000);
        driveInst(opAddi, 1'b0, 3'd0, 3'd0, 3'd3, 3'b000);
        driveInst(opAddi, 1'b0, 3'd0, 3'd0, 3'd2, 3'b000);
        // r2 sits in EX and WB, r3 in MEM
        driveInst(opAdd, 1'b0, 3'd2, 3'd3, 3'd4, 3'b000);
        #1;
        assert (fwdA === fwdEx && fwdB === fwdMem) else begin
            $display("nearest writer did not win for r2 and r3 at %0t", $time);
            errCount++;
        end
        driveInst(opAnd, 1'b0, 3'd0, 3'd4, 3'd1, 3'b000);
        driveInst(opAddi, 1'b0, 3'd0, 3'd0, 3'd0, 3'b000);
        driveInst(opAnd, 1'b0, 3'd0, 3'd0, 3'd5, 3'b000);
        driveInst(opSw, 1'b0, 3'd4, 3'd1, 3'd0, 3'b000);
        finishTest("forwarding priority");

        driveInst(opLw, 1'b0, 3'd0, 3'd0, 3'd5, 3'b000);
        driveInst(opAdd, 1'b0, 3'd5, 3'd1, 3'd6, 3'b000);
        #1;
        assert (stall && ctrl === ctrlNop && !kill) else begin
            $display("dependent add after a load was not held at %0t", $time);
            errCount++;
        end
        waitStallClear();
        assert (controlTop_inst.exEntry === bubbleEntry && fwdA === fwdMem) else begin
            $display("no bubble in EX or load not forwarded from MEM at %0t", $time);
            errCount++;
        end
        finishTest("load-use stall");

        // load to r1 in EX and its consumer in decode when reset hits
        driveInst(opLw, 1'b0, 3'd0, 3'd0, 3'd1, 3'b000);
        driveInst(opAdd, 1'b0, 3'd1, 3'd1, 3'd2, 3'b000);
        rstN = 1'b0;
        #1;
        assert (!stall && fwdA === fwdNone && fwdB === fwdNone) else begin
            $display("stage state survived reset at %0t", $time);
            errCount++;
        end
        applyReset();
        finishTest("reset");

        hold = 1'b0;
        for (i = 0; i < randomCount; i++) begin
            r = $urandom();
            @(negedge clk);
            // a held decode keeps its instruction
            if (!hold) begin
                inst = instFieldsT'(r[13:0]);
            end
            {gt, lt, eq} = r[16:14];
            #1;
            hold = loadUseStall(inst.rs1, inst.rs2, exS, memS, wbS);
        end
        finishTest("random stream");

        $display("checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+testbench
logic/cpuPkg.sv
logic/mainDecoder.sv
logic/pcSelect.sv
logic/hazardUnit.sv
logic/stageTracker.sv
logic/controlTop.sv
testbench/controlTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds controlTb with Verilator and runs it, pass is read from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f sim.f --top-module controlTb -Mdir obj_dir \
    > build.log 2>&1 \
    && ./obj_dir/VcontrolTb > sim.log 2>&1 \
    || { echo "build or run error"; cat build.log; exit 1; }

cat sim.log
grep -qx "Test completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
